// ==== verilog/avr_consts.svh ====
`ifndef AVR_CONSTS_SVH
`define AVR_CONSTS_SVH

// Bus and register widths
`define AVR_DATA_W      8
`define AVR_ADDR_W      16
`define AVR_INSTR_W     16
`define AVR_REG_IDX_W   5

// X pointer bytes in the register file
`define AVR_REG_XL      26
`define AVR_REG_XH      27

// Status register bit positions
`define AVR_FLAG_C      0
`define AVR_FLAG_Z      1
`define AVR_FLAG_N      2
`define AVR_FLAG_V      3
`define AVR_FLAG_S      4
`define AVR_FLAG_H      5
`define AVR_FLAG_T      6
`define AVR_FLAG_I      7

`endif

// ==== verilog/avr_pkg.sv ====
package avr_pkg;

    // ALU function select
    typedef enum logic [2:0] {
        PASS = 3'd0,    // Result is operand b, flags untouched
        ADD  = 3'd1,
        ADC  = 3'd2,
        SUB  = 3'd3,
        SBC  = 3'd4,
        AND  = 3'd5,
        EOR  = 3'd6,
        OR   = 3'd7
    } alu_op_e;

    // Instruction class seen by execute
    typedef enum logic [2:0] {
        NOP    = 3'd0,
        ALU    = 3'd1,
        LOAD   = 3'd2,
        STORE  = 3'd3,
        JUMP   = 3'd4,
        BRANCH = 3'd5
    } op_kind_e;

    // X addressing form of LD/ST
    typedef enum logic [1:0] {
        PLAIN    = 2'd0,
        POST_INC = 2'd1,
        PRE_DEC  = 2'd2
    } ptr_mode_e;

    typedef struct packed {
        logic i;
        logic t;
        logic h;
        logic s;
        logic v;
        logic n;
        logic z;
        logic c;
    } sreg_t;

endpackage

// ==== verilog/avr_op_if.sv ====
`timescale 1ns/1ps

interface avr_op_if;
    import avr_pkg::*;

    op_kind_e  kind;
    alu_op_e   alu_op;
    logic [4:0] rd_idx;         // Destination, also ST source
    logic [4:0] rr_idx;
    logic [7:0] imm;
    logic       use_imm;        // Operand b from imm instead of Rr
    logic       reg_we;         // Low for compares
    logic       sreg_we;
    ptr_mode_e  ptr_mode;
    logic [2:0] br_bit;         // Status bit tested by BRBS/BRBC
    logic       br_set;         // Branch when bit equals this

    modport fetch (
        output kind, alu_op, rd_idx, rr_idx, imm, use_imm,
               reg_we, sreg_we, ptr_mode, br_bit, br_set
    );

    modport exec (
        input kind, alu_op, rd_idx, rr_idx, imm, use_imm,
              reg_we, sreg_we, ptr_mode, br_bit, br_set
    );

endinterface

// ==== verilog/avr_mem_if.sv ====
`timescale 1ns/1ps

interface avr_mem_if;
    import avr_pkg::*;

    // Execute side of a data access
    logic        req;
    logic        store;
    ptr_mode_e   ptr_mode;
    logic [15:0] x_ptr;
    logic [7:0]  wdata;

    // Answer from the load/store unit
    logic        ptr_we;
    logic [15:0] ptr_new;
    logic        load_valid;
    logic [7:0]  load_data;

    modport exec (
        output req, store, ptr_mode, x_ptr, wdata,
        input  ptr_we, ptr_new, load_valid, load_data
    );

    modport lsu (
        input  req, store, ptr_mode, x_ptr, wdata,
        output ptr_we, ptr_new, load_valid, load_data
    );

endinterface

// ==== verilog/avr_fetch.sv ====
`timescale 1ns/1ps
`include "avr_consts.svh"

module avr_fetch (
    input  logic                    clock,
    input  logic                    arst_n_i,
    input  logic [`AVR_INSTR_W-1:0] instr_i,
    output logic [`AVR_ADDR_W-1:0]  pc_o,
    input  logic                    hold_i,         // Load wait state
    input  logic                    branch_take_i,
    avr_op_if.fetch                 op
);
    import avr_pkg::*;

    localparam logic [`AVR_ADDR_W-1:0] PC_STEP = 1;

    logic [`AVR_ADDR_W-1:0] pc;
    logic [`AVR_ADDR_W-1:0] pc_inc;
    logic [`AVR_ADDR_W-1:0] offset;
    logic [`AVR_ADDR_W-1:0] target;
    logic                   is_rjmp;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    always_comb begin
        op.kind     = NOP;
        op.alu_op   = PASS;
        op.rd_idx   = instr_i[8:4];
        op.rr_idx   = {instr_i[9], instr_i[3:0]};
        op.imm      = {instr_i[11:8], instr_i[3:0]};
        op.use_imm  = 1'b0;
        op.reg_we   = 1'b0;
        op.sreg_we  = 1'b0;
        op.ptr_mode = PLAIN;
        op.br_bit   = instr_i[2:0];
        op.br_set   = ~instr_i[10];    // BRBS has bit 10 clear

        casez (instr_i)
            // Two-register ALU group
            16'b0000_01??_????_????: begin op.kind = ALU; op.alu_op = SBC; end    // CPC
            16'b0000_10??_????_????: begin op.kind = ALU; op.alu_op = SBC; end
            16'b0000_11??_????_????: begin op.kind = ALU; op.alu_op = ADD; end
            16'b0001_01??_????_????: begin op.kind = ALU; op.alu_op = SUB; end    // CP
            16'b0001_10??_????_????: begin op.kind = ALU; op.alu_op = SUB; end
            16'b0001_11??_????_????: begin op.kind = ALU; op.alu_op = ADC; end
            16'b0010_00??_????_????: begin op.kind = ALU; op.alu_op = AND; end
            16'b0010_01??_????_????: begin op.kind = ALU; op.alu_op = EOR; end
            16'b0010_10??_????_????: begin op.kind = ALU; op.alu_op = OR;  end
            16'b0010_11??_????_????: begin op.kind = ALU; op.alu_op = PASS; end   // MOV

            // Immediate group, Rd in r16..r31
            16'b0011_????_????_????: begin op.kind = ALU; op.alu_op = SUB; end    // CPI
            16'b0100_????_????_????: begin op.kind = ALU; op.alu_op = SBC; end
            16'b0101_????_????_????: begin op.kind = ALU; op.alu_op = SUB; end
            16'b0110_????_????_????: begin op.kind = ALU; op.alu_op = OR;  end
            16'b0111_????_????_????: begin op.kind = ALU; op.alu_op = AND; end
            16'b1110_????_????_????: begin op.kind = ALU; op.alu_op = PASS; end   // LDI

            16'b1100_????_????_????: op.kind = JUMP;
            16'b1111_0???_????_????: op.kind = BRANCH;

            // LD/ST through X, 1111 is PUSH/POP
            16'b1001_00??_????_11??: begin
                if (instr_i[1:0] != 2'b11) begin
                    op.kind     = instr_i[9] ? STORE : LOAD;
                    op.ptr_mode = ptr_mode_e'(instr_i[1:0]);
                end
            end
            default: op.kind = NOP;
        endcase

        if (instr_i[15:14] == 2'b01 || instr_i[15:12] == 4'b0011
                || instr_i[15:12] == 4'b1110) begin
            op.rd_idx  = {1'b1, instr_i[7:4]};
            op.use_imm = 1'b1;
        end

        if (op.kind == ALU) begin
            // Compares only touch flags, MOV and LDI only the register
            op.reg_we  = (instr_i[15:10] != 6'b000001) && (instr_i[15:10] != 6'b000101)
                         && (instr_i[15:12] != 4'b0011);
            op.sreg_we = (op.alu_op != PASS);
        end
    end

    // ----------------------------------------
    // Next PC
    // ----------------------------------------
    assign is_rjmp = (instr_i[15:12] == 4'b1100);
    assign pc_inc  = pc + PC_STEP;
    assign offset  = is_rjmp ? {{(`AVR_ADDR_W-12){instr_i[11]}}, instr_i[11:0]}
                             : {{(`AVR_ADDR_W-7){instr_i[9]}}, instr_i[9:3]};
    assign target  = pc_inc + offset;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else if (!hold_i) begin
            pc <= (is_rjmp || branch_take_i) ? target : pc_inc;
        end
    end

    assign pc_o = pc;

endmodule

// ==== verilog/avr_alu.sv ====
`timescale 1ns/1ps
`include "avr_consts.svh"

module avr_alu (
    input  avr_pkg::alu_op_e        op_i,
    input  logic [`AVR_DATA_W-1:0]  a_i,        // Rd
    input  logic [`AVR_DATA_W-1:0]  b_i,        // Rr or immediate
    input  avr_pkg::sreg_t          sreg_i,
    output logic [`AVR_DATA_W-1:0]  res_o,
    output avr_pkg::sreg_t          sreg_o
);
    import avr_pkg::*;

    logic [`AVR_DATA_W:0]   wide;       // Extra bit holds carry or borrow
    logic [`AVR_DATA_W-1:0] res;
    logic [7:0]             flags;
    logic                   cin;

    always_comb begin
        flags = sreg_i;
        res   = b_i;
        wide  = '0;
        cin   = ((op_i == ADC) || (op_i == SBC)) ? sreg_i.c : 1'b0;

        case (op_i)
            ADD, ADC: begin
                wide = {1'b0, a_i} + {1'b0, b_i} + {{`AVR_DATA_W{1'b0}}, cin};
                res  = wide[`AVR_DATA_W-1:0];
                flags[`AVR_FLAG_H] = (a_i[3] & b_i[3]) | (b_i[3] & ~res[3])
                                   | (~res[3] & a_i[3]);
                flags[`AVR_FLAG_V] = (a_i[7] & b_i[7] & ~res[7])
                                   | (~a_i[7] & ~b_i[7] & res[7]);
                flags[`AVR_FLAG_C] = wide[`AVR_DATA_W];
            end

            SUB, SBC: begin
                wide = {1'b0, a_i} - {1'b0, b_i} - {{`AVR_DATA_W{1'b0}}, cin};
                res  = wide[`AVR_DATA_W-1:0];
                flags[`AVR_FLAG_H] = (~a_i[3] & b_i[3]) | (b_i[3] & res[3])
                                   | (res[3] & ~a_i[3]);
                flags[`AVR_FLAG_V] = (a_i[7] & ~b_i[7] & ~res[7])
                                   | (~a_i[7] & b_i[7] & res[7]);
                flags[`AVR_FLAG_C] = wide[`AVR_DATA_W];   // Borrow
            end

            // Logic ops keep C and H
            AND: begin
                res = a_i & b_i;
                flags[`AVR_FLAG_V] = 1'b0;
            end
            EOR: begin
                res = a_i ^ b_i;
                flags[`AVR_FLAG_V] = 1'b0;
            end
            OR: begin
                res = a_i | b_i;
                flags[`AVR_FLAG_V] = 1'b0;
            end

            default: res = b_i;     // MOV, LDI
        endcase

        if (op_i != PASS) begin
            flags[`AVR_FLAG_N] = res[7];
            // SBC/CPC chain Z across bytes of a wide compare
            flags[`AVR_FLAG_Z] = (res == '0) && ((op_i != SBC) || sreg_i.z);
            flags[`AVR_FLAG_S] = flags[`AVR_FLAG_N] ^ flags[`AVR_FLAG_V];
        end
    end

    assign res_o  = res;
    assign sreg_o = sreg_t'(flags);

endmodule

// ==== verilog/avr_execute.sv ====
`timescale 1ns/1ps
`include "avr_consts.svh"

module avr_execute (
    input  logic    clock,
    input  logic    arst_n_i,
    avr_op_if.exec  op,
    avr_mem_if.exec mem,
    output logic    branch_take_o
);
    import avr_pkg::*;

    localparam int NUM_REGS = 1 << `AVR_REG_IDX_W;

    logic [`AVR_DATA_W-1:0] regs [NUM_REGS];
    sreg_t                  sreg;
    logic [7:0]             sreg_bits;

    logic [`AVR_DATA_W-1:0] op_a;
    logic [`AVR_DATA_W-1:0] op_b;
    logic [`AVR_DATA_W-1:0] alu_res;
    sreg_t                  alu_sreg;
    logic                   is_alu;

    // ----------------------------------------
    // Operands and ALU
    // ----------------------------------------
    assign is_alu = (op.kind == ALU);
    assign op_a   = regs[op.rd_idx];
    assign op_b   = op.use_imm ? op.imm : regs[op.rr_idx];

    avr_alu alu0 (
        .op_i   (op.alu_op),
        .a_i    (op_a),
        .b_i    (op_b),
        .sreg_i (sreg),
        .res_o  (alu_res),
        .sreg_o (alu_sreg)
    );

    // Branch condition from the current flags
    assign sreg_bits     = sreg;
    assign branch_take_o = (op.kind == BRANCH) && (sreg_bits[op.br_bit] == op.br_set);

    // Data access request, ST sends Rd
    assign mem.req      = (op.kind == LOAD) || (op.kind == STORE);
    assign mem.store    = (op.kind == STORE);
    assign mem.ptr_mode = op.ptr_mode;
    assign mem.x_ptr    = {regs[`AVR_REG_XH], regs[`AVR_REG_XL]};
    assign mem.wdata    = regs[op.rd_idx];

    // ----------------------------------------
    // Register file and SREG
    // ----------------------------------------
    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            sreg <= '0;
        end else begin
            if (is_alu && op.reg_we) begin
                regs[op.rd_idx] <= alu_res;
            end
            if (is_alu && op.sreg_we) begin
                sreg <= alu_sreg;
            end

            // X update on the issue edge of LD/ST
            if (mem.ptr_we) begin
                regs[`AVR_REG_XL] <= mem.ptr_new[`AVR_DATA_W-1:0];
                regs[`AVR_REG_XH] <= mem.ptr_new[`AVR_ADDR_W-1:`AVR_DATA_W];
            end

            if (mem.load_valid) begin
                regs[op.rd_idx] <= mem.load_data;   // Second cycle of LD
            end
        end
    end

endmodule

// ==== verilog/avr_lsu.sv ====
`timescale 1ns/1ps
`include "avr_consts.svh"

module avr_lsu (
    input  logic                   clock,
    input  logic                   arst_n_i,
    avr_mem_if.lsu                 mem,
    output logic                   hold_o,
    output logic [`AVR_ADDR_W-1:0] mem_addr_o,
    output logic [`AVR_DATA_W-1:0] mem_wdata_o,
    output logic                   mem_wren_o,
    input  logic [`AVR_DATA_W-1:0] mem_rdata_i
);
    import avr_pkg::*;

    localparam logic [`AVR_ADDR_W-1:0] PTR_STEP = 1;

    logic                   waiting;    // LD data phase
    logic                   issue;
    logic [`AVR_ADDR_W-1:0] x_inc;
    logic [`AVR_ADDR_W-1:0] x_dec;
    logic [`AVR_ADDR_W-1:0] eff_addr;

    assign issue    = mem.req && !waiting;  // Held LD is seen twice
    assign x_inc    = mem.x_ptr + PTR_STEP;
    assign x_dec    = mem.x_ptr - PTR_STEP;
    assign eff_addr = (mem.ptr_mode == PRE_DEC) ? x_dec : mem.x_ptr;

    assign mem.ptr_we     = issue && (mem.ptr_mode != PLAIN);
    assign mem.ptr_new    = (mem.ptr_mode == POST_INC) ? x_inc : x_dec;
    assign mem.load_valid = waiting;
    assign mem.load_data  = mem_rdata_i;

    assign hold_o = issue && !mem.store;    // Stall pc for the LD wait cycle

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            waiting     <= 1'b0;
            mem_addr_o  <= '0;
            mem_wdata_o <= '0;
            mem_wren_o  <= 1'b0;
        end else begin
            mem_wren_o <= issue && mem.store;   // One-cycle strobe
            waiting    <= issue && !mem.store;
            if (issue) begin
                mem_addr_o <= eff_addr;
                if (mem.store) begin
                    mem_wdata_o <= mem.wdata;
                end
            end
        end
    end

endmodule

// ==== verilog/avr_core.sv ====
`timescale 1ns/1ps
`include "avr_consts.svh"

module avr_core (
    input  logic                    clock,
    input  logic                    arst_n_i,
    output logic [`AVR_ADDR_W-1:0]  pc_o,
    input  logic [`AVR_INSTR_W-1:0] instr_i,
    output logic [`AVR_ADDR_W-1:0]  mem_addr_o,
    output logic [`AVR_DATA_W-1:0]  mem_wdata_o,
    output logic                    mem_wren_o,
    input  logic [`AVR_DATA_W-1:0]  mem_rdata_i
);

    avr_op_if  op_bus ();
    avr_mem_if mem_bus ();

    logic branch_take;
    logic hold;

    avr_fetch fetch0 (
        .clock         (clock),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr_i),
        .pc_o          (pc_o),
        .hold_i        (hold),
        .branch_take_i (branch_take),
        .op            (op_bus.fetch)
    );

    avr_execute execute0 (
        .clock         (clock),
        .arst_n_i      (arst_n_i),
        .op            (op_bus.exec),
        .mem           (mem_bus.exec),
        .branch_take_o (branch_take)
    );

    avr_lsu lsu0 (
        .clock       (clock),
        .arst_n_i    (arst_n_i),
        .mem         (mem_bus.lsu),
        .hold_o      (hold),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wren_o  (mem_wren_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// ==== tests/tb_avr_core.sv ====
`timescale 1ns/1ps

module tb_avr_core;

    localparam int          CYCLE_LIMIT = 2000;     // 5 x (16 + 80) cycles plus margin
    localparam logic [15:0] SELF_LOOP   = 16'hCFFF; // RJMP .-1

    logic        clock;
    logic        arst_n_i;
    logic [15:0] pc_o;
    logic [15:0] instr_i;
    logic [15:0] mem_addr_o;
    logic [7:0]  mem_wdata_o;
    logic        mem_wren_o;
    logic [7:0]  mem_rdata_i;

    logic [15:0] prog [256];
    logic [7:0]  dmem [256];
    int          wr_count [256];
    logic [7:0]  exp_bytes [16];
    int          n_instr;
    int          n_exp;
    int          total_writes;
    int          ld_checks;         // LD stalls measured in the current run
    int          cycles = 0;
    int          errors = 0;
    int          test_errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    integer      seed;

    avr_core dut0 (
        .clock       (clock),
        .arst_n_i    (arst_n_i),
        .pc_o        (pc_o),
        .instr_i     (instr_i),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wren_o  (mem_wren_o),
        .mem_rdata_i (mem_rdata_i)
    );

    // Both memories answer combinationally
    assign instr_i     = prog[pc_o[7:0]];
    assign mem_rdata_i = dmem[mem_addr_o[7:0]];

    always @(posedge clock) begin
        if (mem_wren_o) begin
            dmem[mem_addr_o[7:0]]     <= mem_wdata_o;
            wr_count[mem_addr_o[7:0]] <= wr_count[mem_addr_o[7:0]] + 1;
            total_writes              <= total_writes + 1;
        end
    end

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a program never reached its end loop", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Instruction encoding and reference model
    // ----------------------------------------
    function automatic logic [15:0] rr_op(input logic [5:0] opc, input int d, input int r);
        return {opc, r[4], d[4:0], r[3:0]};
    endfunction

    function automatic logic [15:0] imm_op(input logic [3:0] opc, input int d,
                                           input logic [7:0] k);
        return {opc, k[7:4], d[3:0], k[3:0]};     // Rd is r16..r31
    endfunction

    // Mode 0 is X, 1 is X+, 2 is -X
    function automatic logic [15:0] ld_x(input int d, input logic [1:0] mode);
        return {7'b1001000, d[4:0], 2'b11, mode};
    endfunction

    function automatic logic [15:0] st_x(input int r, input logic [1:0] mode);
        return {7'b1001001, r[4:0], 2'b11, mode};
    endfunction

    function automatic logic [15:0] rjmp(input logic [11:0] k);
        return {4'hC, k};
    endfunction

    function automatic logic [15:0] branch(input logic set, input logic [2:0] flag_bit,
                                           input logic [6:0] k);
        return {5'b11110, ~set, k, flag_bit};     // BRBS or BRBC
    endfunction

    function automatic logic is_ld(input logic [15:0] w);
        return (w[15:9] == 7'b1001000) && (w[3:2] == 2'b11) && (w[1:0] != 2'b11);
    endfunction

    function automatic logic [8:0] add_ref(input logic [7:0] a, b, input logic cin);
        return {1'b0, a} + {1'b0, b} + {8'd0, cin};  // {C, sum}
    endfunction

    // Returns {V, N, Z, C, difference}, chained Z survives only if it was set
    function automatic logic [11:0] sub_ref(input logic [7:0] a, b, input logic cin, zin, chain);
        logic [8:0] d;
        logic       z;
        logic       v;
        d = {1'b0, a} - {1'b0, b} - {8'd0, cin};
        z = (d[7:0] == 8'h00) && (!chain || zin);
        v = (a[7] != b[7]) && (d[7] != a[7]);
        return {v, d[7], z, d[8], d[7:0]};
    endfunction

    // ----------------------------------------
    // Run control and reporting
    // ----------------------------------------
    task automatic report_mismatch(input string name, input logic [15:0] exp, act);
        $display("[ERROR] %0t: %s expected %h, got %h", $time, name, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic emit(input logic [15:0] w);
        prog[n_instr] = w;
        n_instr++;
    endtask

    task automatic expect_byte(input logic [7:0] v);
        exp_bytes[n_exp] = v;
        n_exp++;
    endtask

    // Holds the core in reset while both memories are refilled
    task automatic begin_test();
        int fill;
        arst_n_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            fill        = i * 29 + 59;
            prog[i]     = 16'h0000;
            dmem[i]     = fill[7:0];
            wr_count[i] = 0;
        end
        n_instr      = 0;
        n_exp        = 0;
        total_writes = 0;
        ld_checks    = 0;
        test_errors  = 0;
    endtask

    task automatic run_program();
        logic [15:0] last_pc;
        logic        last_ld;
        logic        done;
        int          stay;
        repeat (16) begin
            @(negedge clock);
            if (pc_o !== 16'h0000) report_mismatch("pc_o", 16'h0000, pc_o);
            if (mem_wren_o !== 1'b0) report_mismatch("mem_wren_o", 16'h0000, mem_wren_o);
            if (mem_addr_o !== 16'h0000) report_mismatch("mem_addr_o", 16'h0000, mem_addr_o);
            if (mem_wdata_o !== 8'h00) report_mismatch("mem_wdata_o", 16'h0000, mem_wdata_o);
        end
        arst_n_i = 1'b1;
        last_pc  = 16'h0000;
        last_ld  = is_ld(prog[0]);
        stay     = 1;
        done     = 1'b0;
        while (!done) begin
            @(negedge clock);
            if (pc_o == last_pc) begin
                stay++;
            end else begin
                if (last_ld) begin
                    ld_checks++;
                    if (stay != 2) begin
                        report_failure($sformatf("LD at pc %h held pc_o for %0d cycles, not 2",
                                                 last_pc, stay));
                    end
                end
                stay = 1;
            end
            last_pc = pc_o;
            last_ld = is_ld(instr_i);
            done    = (instr_i == SELF_LOOP);
        end
        repeat (2) @(negedge clock);    // Last ST lands in memory
    endtask

    task automatic check_stored(input int base);
        for (int i = 0; i < n_exp; i++) begin
            if (dmem[base + i] !== exp_bytes[i]) begin
                report_mismatch($sformatf("dmem[%02h]", base + i), exp_bytes[i], dmem[base + i]);
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_behavior();
        begin_test();
        emit(imm_op(4'hE, 16, 8'hA5));      // Only runs if fetch starts at 0
        emit(st_x(16, 2'd0));
        emit(SELF_LOOP);
        run_program();
        expect_byte(8'hA5);
        check_stored(0);
        end_test("reset");
    endtask

    // LDI r16 before each op, result stored through X+
    task automatic alu_step(input logic [7:0] a, input logic [15:0] w);
        emit(imm_op(4'hE, 16, a));
        emit(w);
        emit(st_x(16, 2'd1));
    endtask

    task automatic alu_results();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  k;
        logic [8:0]  s;
        logic [11:0] d;
        a = $random(seed);
        b = $random(seed);
        k = $random(seed);
        begin_test();
        emit(imm_op(4'hE, 26, 8'h40));
        emit(imm_op(4'hE, 27, 8'h00));
        emit(imm_op(4'hE, 17, b));
        alu_step(a, rr_op(6'b000011, 16, 17));  // ADD
        s = add_ref(a, b, 1'b0);
        expect_byte(s[7:0]);
        alu_step(a, rr_op(6'b000111, 16, 17));  // ADC
        s = add_ref(a, b, s[8]);
        expect_byte(s[7:0]);
        alu_step(a, rr_op(6'b000110, 16, 17));  // SUB
        d = sub_ref(a, b, 1'b0, 1'b0, 1'b0);
        expect_byte(d[7:0]);
        alu_step(a, rr_op(6'b000010, 16, 17));  // SBC
        d = sub_ref(a, b, d[8], 1'b0, 1'b0);
        expect_byte(d[7:0]);
        alu_step(a, rr_op(6'b001000, 16, 17));  // AND
        expect_byte(a & b);
        alu_step(a, rr_op(6'b001001, 16, 17));  // EOR
        expect_byte(a ^ b);
        alu_step(a, rr_op(6'b001010, 16, 17));  // OR
        expect_byte(a | b);
        alu_step(a, imm_op(4'h5, 16, k));       // SUBI
        d = sub_ref(a, k, 1'b0, 1'b0, 1'b0);
        expect_byte(d[7:0]);
        alu_step(a, imm_op(4'h4, 16, k));       // SBCI
        d = sub_ref(a, k, d[8], 1'b0, 1'b0);
        expect_byte(d[7:0]);
        alu_step(a, imm_op(4'h7, 16, k));       // ANDI
        expect_byte(a & k);
        alu_step(a, imm_op(4'h6, 16, k));       // ORI
        expect_byte(a | k);
        alu_step(a, rr_op(6'b001011, 16, 17));  // MOV
        expect_byte(b);
        emit(SELF_LOOP);
        run_program();
        check_stored(8'h40);
        end_test("alu");
    endtask

    // Taken path keeps marker A0+idx, fall-through overwrites it with 30+idx
    task automatic branch_case(input logic [15:0] cmp, input logic [11:0] f,
                               input logic [2:0] flag_bit, input logic set, input int idx);
        logic [3:0] flags;
        flags = f[11:8];
        emit(imm_op(4'hE, 20, 8'hA0 + idx[7:0]));
        emit(cmp);
        emit(branch(set, flag_bit, 7'h01));
        emit(imm_op(4'hE, 20, 8'h30 + idx[7:0]));
        emit(st_x(20, 2'd1));
        if (flags[flag_bit] == set) expect_byte(8'hA0 + idx[7:0]);
        else expect_byte(8'h30 + idx[7:0]);
    endtask

    task automatic compare_branches();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  k;
        logic [11:0] f;
        a = $random(seed);
        b = $random(seed);
        k = $random(seed);
        begin_test();
        emit(imm_op(4'hE, 26, 8'h50));
        emit(imm_op(4'hE, 27, 8'h00));
        emit(imm_op(4'hE, 16, a));
        emit(imm_op(4'hE, 17, b));
        f = sub_ref(a, b, 1'b0, 1'b0, 1'b0);
        branch_case(rr_op(6'b000101, 16, 17), f, 3'd0, 1'b1, 0);   // CP, BRBS C
        f = sub_ref(b, a, f[8], f[9], 1'b1);
        branch_case(rr_op(6'b000001, 17, 16), f, 3'd0, 1'b0, 1);   // CPC, BRBC C
        f = sub_ref(a, a, 1'b0, 1'b0, 1'b0);
        branch_case(rr_op(6'b000101, 16, 16), f, 3'd1, 1'b1, 2);   // CP, BRBS Z
        emit(imm_op(4'hE, 18, 8'h01));      // Nonzero compare clears Z and C
        emit(imm_op(4'h3, 18, 8'h00));
        f = sub_ref(8'h01, 8'h00, 1'b0, 1'b0, 1'b0);
        f = sub_ref(a, a, f[8], f[9], 1'b1);
        branch_case(rr_op(6'b000001, 16, 16), f, 3'd1, 1'b1, 3);   // CPC, BRBS Z
        f = sub_ref(a, k, 1'b0, 1'b0, 1'b0);
        branch_case(imm_op(4'h3, 16, k), f, 3'd2, 1'b1, 4);        // CPI, BRBS N
        f = sub_ref(b, a, 1'b0, 1'b0, 1'b0);
        branch_case(rr_op(6'b000101, 17, 16), f, 3'd3, 1'b0, 5);   // CP, BRBC V
        f = sub_ref(b, k, 1'b0, 1'b0, 1'b0);
        branch_case(imm_op(4'h3, 17, k), f, 3'd1, 1'b0, 6);        // CPI, BRBC Z
        emit(st_x(16, 2'd1));               // Compared registers unchanged
        emit(st_x(17, 2'd1));
        expect_byte(a);
        expect_byte(b);
        emit(SELF_LOOP);
        run_program();
        check_stored(8'h50);
        end_test("branches");
    endtask

    task automatic pointer_loads();
        begin_test();
        for (int i = 8'h1E; i <= 8'h22; i++) begin
            dmem[i] = $random(seed);
        end
        expect_byte(dmem[8'h20]);           // X
        expect_byte(dmem[8'h20]);           // X+
        expect_byte(dmem[8'h21]);           // X after increment
        expect_byte(dmem[8'h20]);           // -X
        expect_byte(dmem[8'h1F]);           // -X again
        expect_byte(dmem[8'h1F]);
        emit(imm_op(4'hE, 26, 8'h20));
        emit(imm_op(4'hE, 27, 8'h00));
        emit(ld_x(0, 2'd0));
        emit(ld_x(1, 2'd1));
        emit(ld_x(2, 2'd0));
        emit(ld_x(3, 2'd2));
        emit(ld_x(4, 2'd2));
        emit(ld_x(5, 2'd0));
        emit(imm_op(4'hE, 26, 8'h80));
        for (int r = 0; r < 6; r++) begin
            emit(st_x(r, 2'd1));
        end
        emit(SELF_LOOP);
        run_program();
        check_stored(8'h80);
        if (ld_checks != 6) begin
            report_failure($sformatf("Only %0d of 6 LD stalls were measured", ld_checks));
        end
        end_test("loads");
    endtask

    task automatic jump_paths();
        logic [31:0] r;
        logic [7:0]  n;
        r = $random(seed);
        n = 8'd3 + {6'd0, r[1:0]};          // Loop count 3..6
        begin_test();
        emit(imm_op(4'hE, 26, 8'h60));
        emit(imm_op(4'hE, 27, 8'h00));
        emit(imm_op(4'hE, 20, 8'h11));
        emit(st_x(20, 2'd1));
        emit(rjmp(12'h001));                // Over the next ST
        emit(st_x(20, 2'd1));
        emit(imm_op(4'hE, 26, 8'h70));
        emit(imm_op(4'hE, 21, n));
        emit(imm_op(4'hE, 22, 8'h01));
        emit(st_x(21, 2'd1));               // Loop body at address 9
        emit(rr_op(6'b000110, 21, 22));
        emit(branch(1'b1, 3'd1, 7'h01));    // Exit on Z
        emit(rjmp(12'hFFC));                // Back to address 9
        emit(SELF_LOOP);
        run_program();
        expect_byte(8'h11);
        check_stored(8'h60);
        if (wr_count[8'h61] != 0) begin
            report_failure("ST skipped by RJMP still wrote its address");
        end
        if (total_writes != n + 1) report_mismatch("total_writes", n + 1, total_writes);
        n_exp = 0;
        for (int i = 0; i < n; i++) begin
            expect_byte(n - i);
        end
        check_stored(8'h70);
        end_test("rjmp");
    endtask

    initial begin
        arst_n_i = 1'b0;
        seed     = 32'hb595e3c8;
        reset_behavior();
        alu_results();
        compare_branches();
        pointer_loads();
        jump_paths();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== avr_core.f ====
+incdir+verilog
verilog/avr_pkg.sv
verilog/avr_op_if.sv
verilog/avr_mem_if.sv
verilog/avr_fetch.sv
verilog/avr_alu.sv
verilog/avr_execute.sv
verilog/avr_lsu.sv
verilog/avr_core.sv
tests/tb_avr_core.sv

// ==== Bender.yml ====
package:
  name: avr_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/avr_pkg.sv
      - verilog/avr_op_if.sv
      - verilog/avr_mem_if.sv
      - verilog/avr_fetch.sv
      - verilog/avr_alu.sv
      - verilog/avr_execute.sv
      - verilog/avr_lsu.sv
      - verilog/avr_core.sv
  - target: test
    files:
      - tests/tb_avr_core.sv
